//--- memOpmPkg.sv
package memOpmPkg;

	// bus widths
	localparam int addrWidth = 32;
	localparam int tileWidth = 128;
	localparam int tileAddrWidth = 28;

	// byte offset inside one tile
	localparam int tileOffsetWidth = addrWidth - tileAddrWidth;

	// backing DDR model depth, indexed by the low tile-address bits
	localparam int ddrTileCount = 4096;
	localparam int ddrIndexWidth = $clog2(ddrTileCount);

	// bits 4:3 give the direction (01 read, 10 write)
	// low bits 111 select a full tile transfer
	typedef enum logic [4:0] {
		opmReady = 5'b00000,
		opmRdTile = 5'b01111,
		opmWrTile = 5'b10111
	} memOpm;

	// status returned by the answering side of a bus
	typedef enum logic [1:0] {
		okReady = 2'b00,
		okOk = 2'b01,
		okHold = 2'b10
	} memOk;

endpackage

//--- l2CachePkg.sv
package l2CachePkg;

	// direct-mapped geometry
	localparam int lineCount = 64;
	localparam int indexWidth = $clog2(lineCount);

	// full tile address kept as the tag
	localparam int tagWidth = memOpmPkg::tileAddrWidth;

	// valid flags cleared this many lines per cycle during reset
	localparam int sweepLanes = 32;
	localparam int laneWidth = $clog2(sweepLanes);
	localparam int sweepCountWidth = indexWidth - laneWidth;

	typedef struct packed {
		logic valid;
		logic dirty;
	} lineFlags;

endpackage

//--- tileStore.sv
module tileStore (
	input logic clock,
	input logic reset,
	input logic [l2CachePkg::indexWidth-1:0] readIndex,
	input logic writeEnable,
	input logic [l2CachePkg::indexWidth-1:0] writeIndex,
	input logic [l2CachePkg::tagWidth-1:0] writeTag,
	input logic [memOpmPkg::tileWidth-1:0] writeData,
	input logic writeDirty,
	output logic [memOpmPkg::tileWidth-1:0] readData,
	output logic [l2CachePkg::tagWidth-1:0] readTag,
	output logic readValid,
	output logic readDirty
);
	import memOpmPkg::*;
	import l2CachePkg::*;

	logic [tileWidth-1:0] dataArray [lineCount];
	logic [tagWidth-1:0] tagArray [lineCount];
	lineFlags flagArray [lineCount];

	logic [sweepCountWidth-1:0] sweepCount;

	// data and tags, written by the controller only
	always_ff @(posedge clock)
	begin
		if (writeEnable)
		begin
			dataArray[writeIndex] <= writeData;
			tagArray[writeIndex] <= writeTag;
		end
	end

	// flags, swept clear during reset one group of lines per cycle
	// the counter may start anywhere, it wraps over every group in two cycles
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int lane = 0; lane < sweepLanes; lane++)
			begin
				flagArray[{sweepCount, laneWidth'(lane)}] <= '0;
			end
			sweepCount <= sweepCount + 1'b1;
		end
		else if (writeEnable)
		begin
			flagArray[writeIndex] <= '{valid: 1'b1, dirty: writeDirty};
		end
	end

	// one cycle read, a write to the same index shows up a cycle later
	always_ff @(posedge clock)
	begin
		readData <= dataArray[readIndex];
		readTag <= tagArray[readIndex];
		readValid <= flagArray[readIndex].valid;
		readDirty <= flagArray[readIndex].dirty;
	end

	writeIndexKnown: assert property (@(posedge clock) disable iff (reset)
		writeEnable |-> !$isunknown(writeIndex));

endmodule

//--- l2TileCache.sv
module l2TileCache (
	input logic clock,
	input logic reset,
	input logic [memOpmPkg::addrWidth-1:0] memAddr,
	input memOpmPkg::memOpm memOpm,
	input logic [memOpmPkg::tileWidth-1:0] memDataIn,
	output logic [memOpmPkg::tileWidth-1:0] memDataOut,
	output memOpmPkg::memOk memOk,
	output logic [l2CachePkg::indexWidth-1:0] readIndex,
	input logic [memOpmPkg::tileWidth-1:0] readData,
	input logic [l2CachePkg::tagWidth-1:0] readTag,
	input logic readValid,
	input logic readDirty,
	output logic writeEnable,
	output logic [l2CachePkg::indexWidth-1:0] writeIndex,
	output logic [l2CachePkg::tagWidth-1:0] writeTag,
	output logic [memOpmPkg::tileWidth-1:0] writeData,
	output logic writeDirty,
	output logic [memOpmPkg::addrWidth-1:0] ddrAddr,
	output memOpmPkg::memOpm ddrOpm,
	output logic [memOpmPkg::tileWidth-1:0] ddrDataOut,
	input logic [memOpmPkg::tileWidth-1:0] ddrDataIn,
	input memOpmPkg::memOk ddrOk
);
	import memOpmPkg::*;
	import l2CachePkg::*;

	typedef enum logic [2:0] {
		idle,
		lookup,
		compare,
		writeBack,
		fill,
		install,
		respond
	} cacheState;

	cacheState state;

	// request latched while idle
	logic [tileAddrWidth-1:0] reqTile;
	logic [tileWidth-1:0] reqData;
	logic reqWrite;

	// tile returned by the DDR fill
	logic [tileWidth-1:0] fillData;

	logic hit;
	logic victimDirty;

	assign hit = readValid && (readTag == reqTile);
	assign victimDirty = readValid && readDirty;

	// store always looks at the line of the pending request
	assign readIndex = reqTile[indexWidth-1:0];
	assign writeIndex = reqTile[indexWidth-1:0];
	assign writeTag = reqTile;

	// write hit merges the new tile, install puts the fetched tile in clean
	assign writeEnable = (state == install) || ((state == compare) && hit && reqWrite);
	assign writeData = (state == install) ? fillData : reqData;
	assign writeDirty = (state == compare);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			memOk <= okReady;
			ddrOpm <= opmReady;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (memOpm inside {opmRdTile, opmWrTile})
					begin
						memOk <= okHold;
						state <= lookup;
					end
				end
				lookup:
				begin
					state <= compare;
				end
				compare:
				begin
					if (hit)
					begin
						memOk <= okOk;
						state <= respond;
					end
					else if (victimDirty)
					begin
						ddrOpm <= opmWrTile;
						state <= writeBack;
					end
					else
					begin
						ddrOpm <= opmRdTile;
						state <= fill;
					end
				end
				writeBack:
				begin
					// drop to READY for a cycle before the fill goes out
					if (ddrOk == okOk)
					begin
						ddrOpm <= opmReady;
						state <= fill;
					end
				end
				fill:
				begin
					if (ddrOk == okOk)
					begin
						ddrOpm <= opmReady;
						state <= install;
					end
					else if ((ddrOpm == opmReady) && (ddrOk == okReady))
					begin
						ddrOpm <= opmRdTile;
					end
				end
				install:
				begin
					// re-read the line so the compare sees the fresh tile
					state <= lookup;
				end
				respond:
				begin
					memOk <= okReady;
					state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == idle)
		begin
			reqTile <= memAddr[addrWidth-1:tileOffsetWidth];
			reqData <= memDataIn;
			reqWrite <= (memOpm == opmWrTile);
		end

		if (state == compare)
		begin
			memDataOut <= reqWrite ? reqData : readData;
			ddrDataOut <= readData;
			if (victimDirty)
			begin
				ddrAddr <= {readTag, {tileOffsetWidth{1'b0}}};
			end
			else
			begin
				ddrAddr <= {reqTile, {tileOffsetWidth{1'b0}}};
			end
		end

		// after the write-back the same bus carries the fill address
		if ((state == writeBack) && (ddrOk == okOk))
		begin
			ddrAddr <= {reqTile, {tileOffsetWidth{1'b0}}};
		end

		if ((state == fill) && (ddrOk == okOk))
		begin
			fillData <= ddrDataIn;
		end
	end

	okSingleCycle: assert property (@(posedge clock) disable iff (reset)
		(memOk == okOk) |=> (memOk != okOk));

	ddrOpmHeld: assert property (@(posedge clock) disable iff (reset)
		(ddrOk == okHold) |=> $stable(ddrOpm));

endmodule

//--- ddrTileMemory.sv
module ddrTileMemory (
	input logic clock,
	input logic reset,
	input logic [memOpmPkg::addrWidth-1:0] ddrAddr,
	input memOpmPkg::memOpm ddrOpm,
	input logic [memOpmPkg::tileWidth-1:0] ddrDataOut,
	output logic [memOpmPkg::tileWidth-1:0] ddrDataIn,
	output memOpmPkg::memOk ddrOk
);
	import memOpmPkg::*;

	typedef enum logic [1:0] {
		idle,
		busy,
		done
	} ddrState;

	logic [tileWidth-1:0] tileArray [ddrTileCount];

	ddrState state;
	logic [2:0] busyCount;
	logic [7:0] lfsr;
	logic [ddrIndexWidth-1:0] tileIndex;
	logic finishing;

	assign tileIndex = ddrAddr[ddrIndexWidth+tileOffsetWidth-1:tileOffsetWidth];
	assign finishing = (state == busy) && (busyCount == '0);

	// each tile starts out holding its own tile address
	initial
	begin
		for (int i = 0; i < ddrTileCount; i++)
		begin
			tileArray[i] = {4{32'(i)}};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			ddrOk <= okReady;
			busyCount <= '0;
			lfsr <= 8'hb5;
		end
		else
		begin
			// x^8 + x^6 + x^5 + x^4 + 1, free running
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			case (state)
				idle:
				begin
					// busy for 1 to 4 extra cycles, so OK lands 2 to 5 after sampling
					if (ddrOpm != opmReady)
					begin
						busyCount <= {1'b0, lfsr[1:0]} + 3'd1;
						ddrOk <= okHold;
						state <= busy;
					end
				end
				busy:
				begin
					if (finishing)
					begin
						ddrOk <= okOk;
						state <= done;
					end
					else
					begin
						busyCount <= busyCount - 3'd1;
					end
				end
				default:
				begin
					ddrOk <= okReady;
					state <= idle;
				end
			endcase
		end
	end

	always @(posedge clock)
	begin
		if (finishing)
		begin
			if (ddrOpm == opmWrTile)
			begin
				tileArray[tileIndex] <= ddrDataOut;
			end
			else
			begin
				ddrDataIn <= tileArray[tileIndex];
			end
		end
	end

	definedOpm: assert property (@(posedge clock) disable iff (reset)
		ddrOpm inside {opmReady, opmRdTile, opmWrTile});

endmodule

//--- memL2Subsystem.sv
module memL2Subsystem (
	input logic clock,
	input logic reset,
	input logic [memOpmPkg::addrWidth-1:0] memAddr,
	input memOpmPkg::memOpm memOpm,
	input logic [memOpmPkg::tileWidth-1:0] memDataIn,
	output logic [memOpmPkg::tileWidth-1:0] memDataOut,
	output memOpmPkg::memOk memOk
);
	import memOpmPkg::*;
	import l2CachePkg::*;

	// cache to tile store
	logic [indexWidth-1:0] readIndex;
	logic [tileWidth-1:0] readData;
	logic [tagWidth-1:0] readTag;
	logic readValid;
	logic readDirty;
	logic writeEnable;
	logic [indexWidth-1:0] writeIndex;
	logic [tagWidth-1:0] writeTag;
	logic [tileWidth-1:0] writeData;
	logic writeDirty;

	// cache to DDR model
	logic [addrWidth-1:0] ddrAddr;
	memOpmPkg::memOpm ddrOpm;
	logic [tileWidth-1:0] ddrDataOut;
	logic [tileWidth-1:0] ddrDataIn;
	memOpmPkg::memOk ddrOk;

	l2TileCache cache (
		.clock, .reset,
		.memAddr, .memOpm, .memDataIn, .memDataOut, .memOk,
		.readIndex, .readData, .readTag, .readValid, .readDirty,
		.writeEnable, .writeIndex, .writeTag, .writeData, .writeDirty,
		.ddrAddr, .ddrOpm, .ddrDataOut, .ddrDataIn, .ddrOk
	);

	tileStore store (
		.clock, .reset,
		.readIndex, .writeEnable, .writeIndex, .writeTag, .writeData, .writeDirty,
		.readData, .readTag, .readValid, .readDirty
	);

	ddrTileMemory ddrMemory (
		.clock, .reset,
		.ddrAddr, .ddrOpm, .ddrDataOut, .ddrDataIn, .ddrOk
	);

endmodule

//--- memL2Tb.sv
module memL2Tb;
	import memOpmPkg::*;
	import l2CachePkg::*;

	logic clock;
	logic reset;
	logic [addrWidth-1:0] reqAddr;
	memOpmPkg::memOpm reqOpm;
	logic [tileWidth-1:0] reqData;
	logic [tileWidth-1:0] respData;
	memOpmPkg::memOk respOk;

	// one entry per request line of the tests file
	logic [4:0] opQ [$];
	logic [addrWidth-1:0] addrQ [$];
	logic [tileWidth-1:0] dataQ [$];
	logic [tileWidth-1:0] expectQ [$];

	int seed = 92095;
	int dataErrors = 0;
	int statusErrors = 0;
	int setupErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 100;

	memL2Subsystem uut (
		.clock, .reset,
		.memAddr(reqAddr), .memOpm(reqOpm), .memDataIn(reqData),
		.memDataOut(respData), .memOk(respOk)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: the requests did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic loadTests(output bit opened);
		int fd;
		int got;
		int fields;
		string line;
		logic [4:0] op;
		logic [addrWidth-1:0] addr;
		logic [tileWidth-1:0] wdata;
		logic [tileWidth-1:0] expected;
		fd = $fopen("memL2Tests.txt", "r");
		opened = (fd != 0);
		if (opened)
		begin
			while (!$feof(fd))
			begin
				line = "";
				got = $fgets(line, fd);
				// comments and blank lines carry no request
				if ((got > 1) && (line.substr(0, 1) != "//"))
				begin
					fields = $sscanf(line, "%h %h %h %h", op, addr, wdata, expected);
					if ((fields == 4) && ((op == opmRdTile) || (op == opmWrTile)))
					begin
						opQ.push_back(op);
						addrQ.push_back(addr);
						dataQ.push_back(wdata);
						expectQ.push_back(expected);
					end
					else
					begin
						setupErrors++;
						$display("unreadable line in the tests file: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runRequest(input int n);
		int gap;
		reqOpm = memOpmPkg::memOpm'(opQ[n]);
		reqAddr = addrQ[n];
		reqData = dataQ[n];
		@(negedge clock);
		while (respOk == okHold)
		begin
			@(negedge clock);
		end
		assert (respOk == okOk) else
		begin
			statusErrors++;
			$display("FAIL at %0t: request %0d ended with status %s, expected OK",
				$time, n, respOk.name());
		end
		if ((respOk == okOk) && (opQ[n] == opmRdTile))
		begin
			assert (respData === expectQ[n]) else
			begin
				dataErrors++;
				$display("FAIL at %0t: read of %h returned %h, expected %h",
					$time, addrQ[n], respData, expectQ[n]);
			end
		end
		reqOpm = opmReady;
		// idle gap of 1 to 4 cycles, OK must not repeat
		gap = 1 + ($unsigned($random(seed)) % 4);
		repeat (gap)
		begin
			@(negedge clock);
			assert (respOk == okReady) else
			begin
				statusErrors++;
				$display("FAIL at %0t: status %s after request %0d, expected READY",
					$time, respOk.name(), n);
			end
		end
	endtask

	initial
	begin
		bit opened;
		reset = 1'b1;
		reqOpm = opmReady;
		reqAddr = '0;
		reqData = '0;
		loadTests(opened);
		if (!opened)
		begin
			$display("could not open memL2Tests.txt for reading");
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			if (opQ.size() == 0)
			begin
				setupErrors++;
				$display("the tests file holds no requests");
			end
			cycleLimit = 40 * opQ.size() + 100;
			repeat (5) @(negedge clock);
			reset = 1'b0;
			@(negedge clock);
			assert (respOk == okReady) else
			begin
				statusErrors++;
				$display("FAIL at %0t: status %s after reset, expected READY", $time, respOk.name());
			end
			for (int n = 0; n < opQ.size(); n++)
			begin
				runRequest(n);
			end
			$display("errors: data %0d, status %0d, setup %0d", dataErrors, statusErrors, setupErrors);
			if ((dataErrors + statusErrors + setupErrors) == 0)
			begin
				$display("Simulation passed");
			end
			else
			begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

//--- memL2Tests.txt
// opcode address writeData expectedReadData, all hex
// opcode 0f reads a tile and 17 writes one, unused columns are 0
0f 00000010 0 00000001000000010000000100000001
17 00000020 11110002222200023333000244440002 0
0f 00000020 0 11110002222200023333000244440002
17 00000030 11110003222200033333000344440003 0
17 00000430 11110043222200433333004344440043 0
0f 00000030 0 11110003222200033333000344440003
0f 00000430 0 11110043222200433333004344440043
0f 00000050 0 00000005000000050000000500000005
0f 00000450 0 00000045000000450000004500000045
0f 00000050 0 00000005000000050000000500000005
17 00000100 a0000010a1000010a2000010a3000010 0
17 00000110 a0000011a1000011a2000011a3000011 0
0f 00000100 0 a0000010a1000010a2000010a3000010
0f 00000500 0 00000050000000500000005000000050
0f 00000100 0 a0000010a1000010a2000010a3000010
0f 00000110 0 a0000011a1000011a2000011a3000011
17 00000900 b0000090b1000090b2000090b3000090 0
0f 00000500 0 00000050000000500000005000000050
0f 00000900 0 b0000090b1000090b2000090b3000090
17 00001110 c0000111c1000111c2000111c3000111 0
0f 00000110 0 a0000011a1000011a2000011a3000011
0f 00001110 0 c0000111c1000111c2000111c3000111
0f 00003ff0 0 000003ff000003ff000003ff000003ff
17 00003ff0 d00003ffd10003ffd20003ffd30003ff 0
17 00003ff0 e00003ffe10003ffe20003ffe30003ff 0
0f 00003ff0 0 e00003ffe10003ffe20003ffe30003ff
0f 000003f0 0 0000003f0000003f0000003f0000003f
0f 00003ff0 0 e00003ffe10003ffe20003ffe30003ff
0f 00000200 0 00000020000000200000002000000020
17 00000200 55550020666600207777002088880020 0
0f 00000600 0 00000060000000600000006000000060
0f 00000a00 0 000000a0000000a0000000a0000000a0
0f 00000200 0 55550020666600207777002088880020
17 0000fff0 f0000ffff1000ffff2000ffff3000fff 0
0f 000003f0 0 0000003f0000003f0000003f0000003f
0f 0000fff0 0 f0000ffff1000ffff2000ffff3000fff
0f 00000020 0 11110002222200023333000244440002
0f 00000457 0 00000045000000450000004500000045
0f 00000010 0 00000001000000010000000100000001
17 00000010 9abc0001def000011357000124680001 0
0f 00000010 0 9abc0001def000011357000124680001

//--- filelist.f
memOpmPkg.sv
l2CachePkg.sv
tileStore.sv
l2TileCache.sv
ddrTileMemory.sv
memL2Subsystem.sv
memL2Tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP = memL2Tb
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log
SOURCES = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
